/* verilog.f */
+incdir+test
source/isa_pkg.sv
source/pipe_pkg.sv
source/register_file.sv
source/operand_decoder.sv
source/alu.sv
source/execute_stage.sv
source/mips16_exec_top.sv
test/tb_mips16_exec.sv

/* test/tb_vectors.svh */
// Directed program, one instruction per row, all registers start at zero
// Columns are name, word, pc, expected dest, data, is_branch and taken
task automatic load_vectors();
	add_row("li_zext_low",  16'h697F, 16'h0100, 4'd1,     16'h007F, 0, 0); // li r1,0x7f
	add_row("li_zext_high", 16'h6A80, 16'h0101, 4'd2,     16'h0080, 0, 0); // li r2,0x80
	add_row("addu_fwd",     16'hE14D, 16'h0102, 4'd3,     16'h00FF, 0, 0); // addu r3,r1,r2
	add_row("subu_neg",     16'hE153, 16'h0103, 4'd4,     16'hFFFF, 0, 0); // subu r4,r1,r2
	add_row("addiu_wrap",   16'h4C01, 16'h0104, 4'd4,     16'h0000, 0, 0); // addiu r4,1
	add_row("addiu_neg",    16'h49FF, 16'h0105, 4'd1,     16'h007E, 0, 0); // addiu r1,-1
	add_row("addiu3_neg",   16'h43A8, 16'h0106, 4'd5,     16'h00F7, 0, 0); // addiu3 r5,r3,-8
	add_row("addiu3_pos",   16'h41C7, 16'h0107, 4'd6,     16'h0085, 0, 0); // addiu3 r6,r1,7
	add_row("and",          16'hEBCC, 16'h0108, 4'd3,     16'h0085, 0, 0); // and r3,r6
	add_row("or",           16'hEA2D, 16'h0109, 4'd2,     16'h00FE, 0, 0); // or r2,r1
	add_row("cmp_equal",    16'hEBCA, 16'h010A, reg_t,    16'h0000, 0, 0); // cmp r3,r6
	add_row("cmp_differ",   16'hE94A, 16'h010B, reg_t,    16'h0001, 0, 0); // cmp r1,r2
	add_row("move",         16'h7F40, 16'h010C, 4'd7,     16'h00FE, 0, 0); // move r7,r2
	add_row("li_r0",        16'h6881, 16'h010D, 4'd0,     16'h0081, 0, 0); // li r0,0x81

	// Shifts, imm3 of zero means eight
	add_row("sll_by_8",     16'h3500, 16'h010E, 4'd5,     16'h8100, 0, 0); // sll r5,r0,0
	add_row("sra_by_3",     16'h36AF, 16'h010F, 4'd6,     16'hF020, 0, 0); // sra r6,r5,3
	add_row("srl_by_8",     16'h34A2, 16'h0110, 4'd4,     16'h0081, 0, 0); // srl r4,r5,0
	add_row("sra_by_8",     16'h31A3, 16'h0111, 4'd1,     16'hFF81, 0, 0); // sra r1,r5,0
	add_row("li_r2",        16'h6A04, 16'h0112, 4'd2,     16'h0004, 0, 0); // li r2,4
	add_row("srav",         16'hEAC7, 16'h0113, 4'd6,     16'hFF02, 0, 0); // srav r2,r6

	// SP, IH and pc
	add_row("mtsp",         16'h64E0, 16'h0114, reg_sp,   16'h00FE, 0, 0); // mtsp r7
	add_row("addsp_neg",    16'h63FE, 16'h0115, reg_sp,   16'h00FC, 0, 0); // addsp -2
	add_row("addsp_pos",    16'h6310, 16'h0116, reg_sp,   16'h010C, 0, 0); // addsp 0x10
	add_row("mtih",         16'hF101, 16'h0117, reg_ih,   16'hFF81, 0, 0); // mtih r1
	add_row("mfih",         16'hF300, 16'h0118, 4'd3,     16'hFF81, 0, 0); // mfih r3
	add_row("mfpc",         16'hE840, 16'h0119, 4'd0,     16'h011A, 0, 0); // mfpc r0

	// Branches report target and taken
	add_row("b_fwd",        16'h1005, 16'h011A, reg_none, 16'h0120, 1, 1); // b +5
	add_row("b_back",       16'h17FD, 16'h011B, reg_none, 16'h0119, 1, 1); // b -3
	add_row("beqz_not",     16'h2410, 16'h011C, reg_none, 16'h012D, 1, 0); // beqz r4,0x10
	add_row("bnez_taken",   16'h2CFC, 16'h011D, reg_none, 16'h011A, 1, 1); // bnez r4,-4
	add_row("li_r5_zero",   16'h6D00, 16'h011E, 4'd5,     16'h0000, 0, 0); // li r5,0
	add_row("beqz_taken",   16'h2520, 16'h011F, reg_none, 16'h0140, 1, 1); // beqz r5,0x20
	add_row("bteqz_not",    16'h607F, 16'h0120, reg_none, 16'h01A0, 1, 0); // bteqz 0x7f
	add_row("cmp_self",     16'hEECA, 16'h0121, reg_t,    16'h0000, 0, 0); // cmp r6,r6
	add_row("bteqz_taken",  16'h60FF, 16'h0122, reg_none, 16'h0122, 1, 1); // bteqz -1
	add_row("jr",           16'hEF00, 16'h0123, reg_none, 16'h00FE, 1, 1); // jr r7
	add_row("nop",          16'h0800, 16'h0124, reg_none, 16'h0000, 0, 0);

	// Registers read after the branches still hold their values
	add_row("move_r4_kept", 16'h7980, 16'h0125, 4'd1,     16'h0081, 0, 0); // move r1,r4
	add_row("addu_carry",   16'hE3C9, 16'h0126, 4'd2,     16'hFE83, 0, 0); // addu r2,r3,r6
	add_row("mfih_kept",    16'hF000, 16'h0127, 4'd0,     16'hFF81, 0, 0); // mfih r0
	add_row("unsupported",  16'hFFFF, 16'h0128, reg_none, 16'h0000, 0, 0); // Runs as a NOP
endtask

/* test/tb_mips16_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips16_exec;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int clk_period    = 4;
	localparam int random_cycles = 200;

	typedef struct packed {
		reg_idx_t        dest;
		logic [xlen-1:0] data;
		logic            is_branch;
		logic            taken;
	} expect_t;

	typedef struct packed {
		logic [xlen-1:0] word;
		logic [xlen-1:0] pc;
		expect_t         want;
	} vector_t;

	logic            clk;
	logic            arst_n;
	logic            instr_valid;
	instr_u          instr;
	logic [xlen-1:0] pc;
	exec_result_t    result;

	vector_t         vec_q[$];
	string           vec_name[$];
	expect_t         exp_q[$];         // Results still in the pipeline
	int              due_q[$];
	string           name_q[$];
	logic [xlen-1:0] shadow [8];       // R0-R7 as the random section sees them
	integer          seed;
	int              cycle;
	int              limit_ns;
	logic            rows_loaded;

	mips16_exec_top DUT (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.result      (result)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////////////////////////
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("error in %s, expected %0h, actual %0h", name, expected, actual));
		end
	endtask

	task automatic check_result();
		expect_t want;
		string   name;
		int      due;
		if (result.valid) begin
			if (exp_q.size() == 0) begin
				abort_run("a result arrived with no instruction outstanding");
			end else begin
				want = exp_q.pop_front();
				name = name_q.pop_front();
				due  = due_q.pop_front();
				check_value({name, " cycle"}, due, cycle);
				check_value({name, " dest"}, want.dest, result.dest);
				check_value({name, " data"}, want.data, result.data);
				check_value({name, " is_branch"}, want.is_branch, result.is_branch);
				check_value({name, " taken"}, want.taken, result.taken);
			end
		end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
			check_value({name_q[0], " valid"}, 1, 0);  // Result is late
		end
	endtask

	// One clock of stimulus, outputs are checked first while stable
	task automatic apply_cycle(input logic valid, input logic [xlen-1:0] word,
		input logic [xlen-1:0] pc_val, input expect_t want, input string name);
		@(negedge clk);
		cycle++;
		check_result();
		instr_valid = valid;
		instr       = word;
		pc          = pc_val;
		if (valid) begin
			exp_q.push_back(want);
			due_q.push_back(cycle + 3);  // Sampled next edge, out two edges later
			name_q.push_back(name);
		end
	endtask

	task automatic add_row(input string name, input logic [xlen-1:0] word,
		input logic [xlen-1:0] pc_val, input reg_idx_t dest, input logic [xlen-1:0] data,
		input logic is_branch, input logic taken);
		vector_t v;
		v.word = word;
		v.pc   = pc_val;
		v.want = {dest, data, is_branch, taken};
		vec_q.push_back(v);
		vec_name.push_back(name);
	endtask

	`include "tb_vectors.svh"

	//////////////////////////////////////////////////////////////////////
	// Random section
	//////////////////////////////////////////////////////////////////////
	function automatic logic [xlen-1:0] encode_rrr(input logic [2:0] rx, input logic [2:0] ry,
		input logic [2:0] rz, input logic [1:0] funct);
		return {op_rrr, rx, ry, rz, funct};
	endfunction

	function automatic logic [xlen-1:0] encode_rr(input logic [2:0] rx, input logic [2:0] ry,
		input logic [4:0] funct);
		return {op_rr, rx, ry, funct};
	endfunction

	task automatic run_random();
		logic            valid;
		logic [2:0]      rx;
		logic [2:0]      ry;
		logic [2:0]      rz;
		reg_idx_t        dest;
		logic [xlen-1:0] val;
		logic [xlen-1:0] word;
		int              sel;
		string           mnem;
		for (int i = 0; i < 8; i++) begin
			val       = {8'h00, 8'($random(seed))};
			shadow[i] = val;
			apply_cycle(1'b1, {op_li, 3'(i), val[7:0]}, 16'($random(seed)),
				{reg_idx_t'(i), val, 2'b00}, $sformatf("random %0d li", i));
		end
		for (int n = 8; n < random_cycles; n++) begin
			valid = ($random(seed) & 3) != 0;  // About one idle cycle in four
			rx    = 3'($random(seed));
			ry    = 3'($random(seed));
			rz    = 3'($random(seed));
			sel   = $unsigned($random(seed)) % 5;
			case (sel)
				0: begin
					mnem = "addu";
					word = encode_rrr(rx, ry, rz, f_rrr_addu);
					dest = {1'b0, rz};
					val  = shadow[rx] + shadow[ry];
				end
				1: begin
					mnem = "subu";
					word = encode_rrr(rx, ry, rz, f_rrr_subu);
					dest = {1'b0, rz};
					val  = shadow[rx] - shadow[ry];
				end
				2: begin
					mnem = "and";
					word = encode_rr(rx, ry, f_rr_and);
					dest = {1'b0, rx};
					val  = shadow[rx] & shadow[ry];
				end
				3: begin
					mnem = "or";
					word = encode_rr(rx, ry, f_rr_or);
					dest = {1'b0, rx};
					val  = shadow[rx] | shadow[ry];
				end
				default: begin
					mnem = "cmp";
					word = encode_rr(rx, ry, f_rr_cmp);
					dest = reg_t;
					val  = (shadow[rx] != shadow[ry]) ? 16'd1 : 16'd0;
				end
			endcase
			if (valid && dest != reg_t) begin
				shadow[dest[2:0]] = val;
			end
			apply_cycle(valid, word, 16'($random(seed)), {dest, val, 2'b00},
				$sformatf("random %0d %s", n, mnem));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////
	initial begin
		seed        = 32'hca22;
		cycle       = 0;
		rows_loaded = 1'b0;
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = '0;
		load_vectors();
		rows_loaded = 1'b1;

		repeat (8) begin
			@(negedge clk);
			check_value("reset", 0, result.valid);
		end
		arst_n = 1'b1;
		repeat (3) apply_cycle(1'b0, 16'hFFFF, '0, '0, "idle");  // Junk word while idle

		foreach (vec_q[i]) begin
			apply_cycle(1'b1, vec_q[i].word, vec_q[i].pc, vec_q[i].want, vec_name[i]);
		end
		run_random();
		repeat (4) apply_cycle(1'b0, '0, '0, '0, "drain");

		if (exp_q.size() == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			abort_run("some results never arrived before the end of the run");
		end
	end

	initial begin
		wait (rows_loaded);
		limit_ns = (vec_q.size() + random_cycles + 20) * clk_period * 2;
		#(limit_ns);
		abort_run($sformatf("timeout, the run did not finish within %0d ns", limit_ns));
	end

endmodule

`default_nettype wire

/* source/mips16_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips16_exec_top (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     instr_valid,
	input  isa_pkg::instr_u          instr,
	input  logic [isa_pkg::xlen-1:0] pc,
	output pipe_pkg::exec_result_t   result
);
	import isa_pkg::*;
	import pipe_pkg::*;

	reg_idx_t        rd_a_idx;
	reg_idx_t        rd_b_idx;
	logic [xlen-1:0] rd_a_data;
	logic [xlen-1:0] rd_b_data;
	uop_t            uop;
	exec_result_t    fwd;              // Also the write-back port

	operand_decoder u_decoder (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.rd_a_idx    (rd_a_idx),
		.rd_b_idx    (rd_b_idx),
		.rd_a_data   (rd_a_data),
		.rd_b_data   (rd_b_data),
		.fwd         (fwd),
		.uop         (uop)
	);

	register_file u_regs (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_a_idx  (rd_a_idx),
		.rd_b_idx  (rd_b_idx),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data),
		.wr        (fwd)
	);

	execute_stage u_exec (
		.clk    (clk),
		.arst_n (arst_n),
		.uop    (uop),
		.fwd    (fwd),
		.result (result)
	);

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic                   clk,
	input  logic                   arst_n,
	input  pipe_pkg::uop_t         uop,
	output pipe_pkg::exec_result_t fwd,
	output pipe_pkg::exec_result_t result
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [xlen-1:0] alu_res;
	logic            alu_flag;
	logic            cond_branch;

	alu u_alu (
		.op   (uop.op),
		.op1  (uop.op1),
		.op2  (uop.op2),
		.res  (alu_res),
		.flag (alu_flag)
	);

	// B and JR jump unconditionally
	assign cond_branch = (uop.op == alu_eqz) || (uop.op == alu_nez);

	always_comb begin
		fwd.valid     = uop.valid;
		fwd.dest      = uop.dest;
		fwd.data      = alu_res;
		fwd.is_branch = uop.is_branch;
		fwd.taken     = cond_branch ? alu_flag : uop.is_branch;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
		end else begin
			result <= fwd;
		end
	end

	a_taken_is_branch: assert property (
		@(posedge clk) disable iff (!arst_n)
		result.taken |-> result.is_branch
	) else $error("execute_stage: taken set on a non-branch");

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  pipe_pkg::alu_op_t        op,
	input  logic [isa_pkg::xlen-1:0] op1,
	input  logic [isa_pkg::xlen-1:0] op2,
	output logic [isa_pkg::xlen-1:0] res,
	output logic                     flag
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [xlen:0] sum;
	logic [xlen:0] diff;

	// One bit wider for carry and borrow
	assign sum  = {1'b0, op1} + {1'b0, op2};
	assign diff = {1'b0, op1} - {1'b0, op2};

	//////////////////////////////////////////////////////////////////////
	// Operation select
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		res  = '0;
		flag = 1'b0;
		case (op)
			alu_add: begin
				res  = sum[xlen-1:0];
				flag = sum[xlen];              // Carry out
			end
			alu_sub: begin
				res  = diff[xlen-1:0];
				flag = diff[xlen];             // Borrow
			end
			alu_and: begin
				res = op1 & op2;
			end
			alu_or: begin
				res = op1 | op2;
			end
			alu_sll: begin
				res = op1 << op2;
			end
			alu_srl: begin
				res = op1 >> op2;
			end
			alu_sra: begin
				res = $unsigned($signed(op1) >>> op2);  // Sign fill
			end
			alu_pass: begin
				res = op1;
			end
			alu_eqz: begin
				res  = op2;                    // Branch target
				flag = (op1 == '0);
			end
			alu_nez: begin
				res  = op2;
				flag = (op1 != '0);
			end
			alu_neq: begin
				res = {{(xlen-1){1'b0}}, op1 != op2};
			end
			default: begin
				res = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/operand_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_decoder (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     instr_valid,
	input  isa_pkg::instr_u          instr,
	input  logic [isa_pkg::xlen-1:0] pc,
	output isa_pkg::reg_idx_t        rd_a_idx,
	output isa_pkg::reg_idx_t        rd_b_idx,
	input  logic [isa_pkg::xlen-1:0] rd_a_data,
	input  logic [isa_pkg::xlen-1:0] rd_b_data,
	input  pipe_pkg::exec_result_t   fwd,
	output pipe_pkg::uop_t           uop
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic            instr_valid_q;
	instr_u          instr_q;
	logic [xlen-1:0] pc_q;

	reg_idx_t        rx_idx;
	reg_idx_t        ry_idx;
	reg_idx_t        rz_idx;
	logic [4:0]      rr_funct;
	logic [xlen-1:0] pc_next;
	logic [xlen-1:0] sext_imm8;
	logic [xlen-1:0] zext_imm8;
	logic [xlen-1:0] sext_imm4;
	logic [xlen-1:0] sext_imm11;
	logic [xlen-1:0] shamt;
	logic [xlen-1:0] br_target;
	logic            a_hit;
	logic            b_hit;
	logic [xlen-1:0] src_a;
	logic [xlen-1:0] src_b;
	uop_t            uop_next;

	//////////////////////////////////////////////////////////////////////
	// Sampling register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			instr_valid_q <= 1'b0;
		end else begin
			instr_valid_q <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		instr_q <= instr;
		pc_q    <= pc;
	end

	//////////////////////////////////////////////////////////////////////
	// Fields and immediates
	//////////////////////////////////////////////////////////////////////
	assign rx_idx     = {1'b0, instr_q.fmt_rrr.rx};
	assign ry_idx     = {1'b0, instr_q.fmt_rrr.ry};
	assign rz_idx     = {1'b0, instr_q.fmt_rrr.rz};
	assign rr_funct   = {instr_q.fmt_rrr.rz, instr_q.fmt_rrr.funct};
	assign pc_next    = pc_q + 1'b1;
	assign sext_imm8  = {{(xlen-8){instr_q.fmt_i8.imm8[7]}}, instr_q.fmt_i8.imm8};
	assign zext_imm8  = {{(xlen-8){1'b0}}, instr_q.fmt_i8.imm8};
	assign sext_imm4  = {{(xlen-4){instr_q.fmt_i8.imm8[3]}}, instr_q.fmt_i8.imm8[3:0]};
	assign sext_imm11 = {{(xlen-11){instr_q.fmt_i8.rx[2]}}, instr_q.fmt_i8.rx,
		instr_q.fmt_i8.imm8};
	assign shamt      = (instr_q.fmt_sh.imm3 == 3'd0) ? xlen'(8) : xlen'(instr_q.fmt_sh.imm3);
	assign br_target  = pc_next + sext_imm8;

	// Bypass from the op now in execute
	assign a_hit = fwd.valid && (fwd.dest != reg_none) && (fwd.dest == rd_a_idx);
	assign b_hit = fwd.valid && (fwd.dest != reg_none) && (fwd.dest == rd_b_idx);
	assign src_a = a_hit ? fwd.data : rd_a_data;
	assign src_b = b_hit ? fwd.data : rd_b_data;

	always_comb begin
		rd_a_idx           = reg_none;
		rd_b_idx           = reg_none;
		uop_next.valid     = instr_valid_q;
		uop_next.op        = alu_pass;
		uop_next.op1       = src_a;
		uop_next.op2       = src_b;
		uop_next.dest      = reg_none;  // Anything unknown ends up a NOP
		uop_next.is_branch = 1'b0;
		case (instr_q.fmt_i8.opcode)
			op_addiu: begin
				rd_a_idx      = rx_idx;
				uop_next.op   = alu_add;
				uop_next.op2  = sext_imm8;
				uop_next.dest = rx_idx;
			end
			op_addiu3: begin
				rd_a_idx      = rx_idx;
				uop_next.op   = alu_add;
				uop_next.op2  = sext_imm4;
				uop_next.dest = ry_idx;
			end
			op_i8: begin
				case (instr_q.fmt_i8.rx)
					f_i8_addsp: begin
						rd_a_idx      = reg_sp;
						uop_next.op   = alu_add;
						uop_next.op2  = sext_imm8;
						uop_next.dest = reg_sp;
					end
					f_i8_bteqz: begin
						rd_a_idx           = reg_t;
						uop_next.op        = alu_eqz;
						uop_next.op2       = br_target;
						uop_next.is_branch = 1'b1;
					end
					f_i8_mtsp: begin
						rd_a_idx      = ry_idx;
						uop_next.dest = reg_sp;
					end
					default: ;
				endcase
			end
			op_rrr: begin
				rd_a_idx = rx_idx;
				rd_b_idx = ry_idx;
				case (instr_q.fmt_rrr.funct)
					f_rrr_addu: begin
						uop_next.op   = alu_add;
						uop_next.dest = rz_idx;
					end
					f_rrr_subu: begin
						uop_next.op   = alu_sub;
						uop_next.dest = rz_idx;
					end
					default: ;
				endcase
			end
			op_rr: begin
				case (rr_funct)
					f_rr_and, f_rr_or: begin
						rd_a_idx      = rx_idx;
						rd_b_idx      = ry_idx;
						uop_next.op   = (rr_funct == f_rr_and) ? alu_and : alu_or;
						uop_next.dest = rx_idx;
					end
					f_rr_cmp: begin
						rd_a_idx      = rx_idx;
						rd_b_idx      = ry_idx;
						uop_next.op   = alu_neq;
						uop_next.dest = reg_t;
					end
					f_rr_srav: begin
						rd_a_idx      = ry_idx;  // Shifted value
						rd_b_idx      = rx_idx;  // Amount
						uop_next.op   = alu_sra;
						uop_next.dest = ry_idx;
					end
					f_rr_pc: begin
						if (instr_q.fmt_rrr.ry == f_pc_jr) begin
							rd_a_idx           = rx_idx;
							uop_next.is_branch = 1'b1;
						end else if (instr_q.fmt_rrr.ry == f_pc_mfpc) begin
							uop_next.op1  = pc_next;
							uop_next.dest = rx_idx;
						end
					end
					default: ;
				endcase
			end
			op_b: begin
				uop_next.op        = alu_add;
				uop_next.op1       = pc_next;
				uop_next.op2       = sext_imm11;
				uop_next.is_branch = 1'b1;
			end
			op_beqz, op_bnez: begin
				rd_a_idx           = rx_idx;
				uop_next.op        = (instr_q.fmt_i8.opcode == op_beqz) ? alu_eqz : alu_nez;
				uop_next.op2       = br_target;
				uop_next.is_branch = 1'b1;
			end
			op_li: begin
				uop_next.op1  = zext_imm8;
				uop_next.dest = rx_idx;
			end
			op_ih: begin
				if (instr_q.fmt_i8.imm8 == f_ih_mfih) begin
					rd_a_idx      = reg_ih;
					uop_next.dest = rx_idx;
				end else if (instr_q.fmt_i8.imm8 == f_ih_mtih) begin
					rd_a_idx      = rx_idx;
					uop_next.dest = reg_ih;
				end
			end
			op_shift: begin
				rd_a_idx      = ry_idx;
				uop_next.op2  = shamt;
				uop_next.dest = rx_idx;
				case (instr_q.fmt_sh.funct)
					f_sh_sll: uop_next.op = alu_sll;
					f_sh_srl: uop_next.op = alu_srl;
					f_sh_sra: uop_next.op = alu_sra;
					default:  uop_next.dest = reg_none;
				endcase
			end
			op_move: begin
				if (rr_funct == f_move) begin
					rd_a_idx      = ry_idx;
					uop_next.dest = rx_idx;
				end
			end
			op_nop: ;                        // Passes zero and writes nothing
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			uop <= '0;
		end else begin
			uop <= uop_next;
		end
	end

	a_uop_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		uop.valid |-> !$isunknown(uop)
	) else $error("operand_decoder: valid uop with unknown ALU op or operands");

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic                     clk,
	input  logic                     arst_n,
	input  isa_pkg::reg_idx_t        rd_a_idx,
	input  isa_pkg::reg_idx_t        rd_b_idx,
	output logic [isa_pkg::xlen-1:0] rd_a_data,
	output logic [isa_pkg::xlen-1:0] rd_b_data,
	input  pipe_pkg::exec_result_t   wr
);
	import isa_pkg::*;

	logic [xlen-1:0] regs [num_regs];
	logic            wr_en;

	assign wr_en = wr.valid && (wr.dest != reg_none) && (wr.dest <= reg_t);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr.dest] <= wr.data;
		end
	end

	// reg_none and unused indexes read as zero
	assign rd_a_data = (rd_a_idx <= reg_t) ? regs[rd_a_idx] : '0;
	assign rd_b_data = (rd_b_idx <= reg_t) ? regs[rd_b_idx] : '0;

	// The decoder must never produce a destination between T and reg_none
	a_wr_dest_legal: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr.valid |-> (wr.dest <= reg_t) || (wr.dest == reg_none)
	) else $error("register_file: illegal write index %0d", wr.dest);

endmodule

`default_nettype wire

/* source/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

	//////////////////////////////////////////////////////////////////////
	// ALU operations
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_sll  = 4'd4,
		alu_srl  = 4'd5,
		alu_sra  = 4'd6,
		alu_pass = 4'd7,                   // res = op1
		alu_eqz  = 4'd8,                   // Branch if op1 == 0, res = op2
		alu_nez  = 4'd9,                   // Branch if op1 != 0, res = op2
		alu_neq  = 4'd10                   // CMP
	} alu_op_t;

	//////////////////////////////////////////////////////////////////////
	// Stage payloads
	//////////////////////////////////////////////////////////////////////

	// Decoder to execute
	typedef struct packed {
		logic                      valid;
		alu_op_t                   op;
		logic [isa_pkg::xlen-1:0]  op1;
		logic [isa_pkg::xlen-1:0]  op2;
		isa_pkg::reg_idx_t         dest;
		logic                      is_branch;
	} uop_t;

	// Execute output, also the write port and forwarding bus
	typedef struct packed {
		logic                      valid;
		isa_pkg::reg_idx_t         dest;
		logic [isa_pkg::xlen-1:0]  data;  // Result or branch target
		logic                      is_branch;
		logic                      taken;
	} exec_result_t;

endpackage

`default_nettype wire

/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	localparam int xlen = 16;                  // Datapath width
	localparam int num_regs = 11;              // R0-R7, SP, IH, T

	//////////////////////////////////////////////////////////////////////
	// Primary opcodes, instr[15:11]
	//////////////////////////////////////////////////////////////////////
	localparam logic [4:0] op_addiu  = 5'b01001;
	localparam logic [4:0] op_addiu3 = 5'b01000;
	localparam logic [4:0] op_i8     = 5'b01100; // ADDSP, BTEQZ, MTSP
	localparam logic [4:0] op_rrr    = 5'b11100; // ADDU, SUBU
	localparam logic [4:0] op_rr     = 5'b11101; // AND, OR, CMP, JR, MFPC, SRAV
	localparam logic [4:0] op_b      = 5'b00010;
	localparam logic [4:0] op_beqz   = 5'b00100;
	localparam logic [4:0] op_bnez   = 5'b00101;
	localparam logic [4:0] op_li     = 5'b01101;
	localparam logic [4:0] op_ih     = 5'b11110; // MFIH, MTIH
	localparam logic [4:0] op_nop    = 5'b00001;
	localparam logic [4:0] op_shift  = 5'b00110;
	localparam logic [4:0] op_move   = 5'b01111;

	//////////////////////////////////////////////////////////////////////
	// Sub-selectors
	//////////////////////////////////////////////////////////////////////
	localparam logic [2:0] f_i8_bteqz = 3'b000;  // In the rx slot
	localparam logic [2:0] f_i8_addsp = 3'b011;
	localparam logic [2:0] f_i8_mtsp  = 3'b100;

	localparam logic [1:0] f_rrr_addu = 2'b01;
	localparam logic [1:0] f_rrr_subu = 2'b11;

	localparam logic [4:0] f_rr_and   = 5'b01100; // instr[4:0]
	localparam logic [4:0] f_rr_or    = 5'b01101;
	localparam logic [4:0] f_rr_cmp   = 5'b01010;
	localparam logic [4:0] f_rr_srav  = 5'b00111;
	localparam logic [4:0] f_rr_pc    = 5'b00000; // JR and MFPC, split on ry
	localparam logic [2:0] f_pc_jr    = 3'b000;
	localparam logic [2:0] f_pc_mfpc  = 3'b010;

	localparam logic [7:0] f_ih_mfih  = 8'h00;
	localparam logic [7:0] f_ih_mtih  = 8'h01;

	localparam logic [1:0] f_sh_sll   = 2'b00;
	localparam logic [1:0] f_sh_srl   = 2'b10;
	localparam logic [1:0] f_sh_sra   = 2'b11;

	localparam logic [4:0] f_move     = 5'b00000;

	// Register indexes, 0-7 are the general registers
	typedef logic [3:0] reg_idx_t;

	localparam reg_idx_t reg_sp   = 4'd8;
	localparam reg_idx_t reg_ih   = 4'd9;
	localparam reg_idx_t reg_t    = 4'd10;
	localparam reg_idx_t reg_none = 4'd15;     // No write-back

	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rx;
		logic [7:0] imm8;
	} fmt_i8_t;

	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rx;
		logic [2:0] ry;
		logic [2:0] rz;
		logic [1:0] funct;
	} fmt_rrr_t;

	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rx;
		logic [2:0] ry;
		logic [2:0] imm3;
		logic [1:0] funct;
	} fmt_sh_t;

	typedef union packed {
		fmt_i8_t  fmt_i8;
		fmt_rrr_t fmt_rrr;
		fmt_sh_t  fmt_sh;
	} instr_u;

endpackage

`default_nettype wire
